// ==== rtl/link_sig_pkg.sv ====
package link_sig_pkg;

    //////////////////////////////////////////////////
    // Datapath widths
    //////////////////////////////////////////////////

    // PRBS state and equation mask
    localparam int PRBS_W = 32;

    // Received channel sample, two's complement
    localparam int SMP_W = 12;

    // Channel tap coefficients, two's complement
    localparam int TAP_W = 8;

    //////////////////////////////////////////////////
    // Datapath items
    //////////////////////////////////////////////////

    // One transmitted symbol, one per unit interval
    typedef struct packed {
        logic vld;
        logic data;
    } link_sym_t;

    // Channel output sample
    typedef struct packed {
        logic                    vld;
        logic signed [SMP_W-1:0] smp;
    } link_smp_t;

endpackage

// ==== rtl/link_cfg_pkg.sv ====
package link_cfg_pkg;

    //////////////////////////////////////////////////
    // APB bus
    //////////////////////////////////////////////////

    localparam int APB_AW = 8;
    localparam int APB_DW = 32;

    //////////////////////////////////////////////////
    // Register map
    //////////////////////////////////////////////////

    localparam logic [APB_AW-1:0] ADDR_CTRL    = 8'h00;
    localparam logic [APB_AW-1:0] ADDR_SEED    = 8'h04;
    localparam logic [APB_AW-1:0] ADDR_EQN     = 8'h08;
    localparam logic [APB_AW-1:0] ADDR_OSC     = 8'h0C;
    localparam logic [APB_AW-1:0] ADDR_TAPS    = 8'h10;
    // Read only from here on
    localparam logic [APB_AW-1:0] ADDR_ERR_CNT = 8'h14;
    localparam logic [APB_AW-1:0] ADDR_BIT_CNT = 8'h18;
    localparam logic [APB_AW-1:0] ADDR_STATUS  = 8'h1C;

    // CTRL bits, inj_err and clear are write-one pulses
    localparam int CTRL_EN_BIT  = 0;
    localparam int CTRL_INJ_BIT = 1;
    localparam int CTRL_CLR_BIT = 2;

    // Byte lanes inside OSC and TAPS
    localparam int LO_FIELD_LSB = 0;
    localparam int HI_FIELD_LSB = 8;

    localparam int OSC_W     = 8;
    localparam int ERR_CNT_W = 16;
    localparam int BIT_CNT_W = 32;

    // Reset values
    localparam logic [link_sig_pkg::PRBS_W-1:0] SEED_RST = 32'h0000_0001;
    localparam logic [link_sig_pkg::PRBS_W-1:0] EQN_RST  = 32'h0000_0060;
    localparam logic [OSC_W-1:0]                OSC_RST  = 8'd2;
    localparam logic signed [link_sig_pkg::TAP_W-1:0] TAP_MAIN_RST = 8'sd64;
    localparam logic signed [link_sig_pkg::TAP_W-1:0] TAP_POST_RST = 8'sd0;

    //////////////////////////////////////////////////
    // Register block outputs and status input
    //////////////////////////////////////////////////

    typedef struct packed {
        logic                                   enable;
        logic [link_sig_pkg::PRBS_W-1:0]        seed;
        logic [link_sig_pkg::PRBS_W-1:0]        eqn;
        logic [OSC_W-1:0]                       t_lo;
        logic [OSC_W-1:0]                       t_hi;
        logic signed [link_sig_pkg::TAP_W-1:0]  tap_main;
        logic signed [link_sig_pkg::TAP_W-1:0]  tap_post;
    } link_cfg_t;

    typedef struct packed {
        logic inj_err;
        logic clear;
    } link_pulse_t;

    typedef struct packed {
        logic [ERR_CNT_W-1:0] err_cnt;
        logic [BIT_CNT_W-1:0] bit_cnt;
        logic                 locked;
    } link_stat_t;

endpackage

// ==== rtl/link_regs.sv ====
`timescale 1ns/10ps

module link_regs (
    input  logic                              emu_clk,
    input  logic                              emu_rst,
    input  logic [link_cfg_pkg::APB_AW-1:0]   paddr_i,
    input  logic                              psel_i,
    input  logic                              penable_i,
    input  logic                              pwrite_i,
    input  logic [link_cfg_pkg::APB_DW-1:0]   pwdata_i,
    output logic [link_cfg_pkg::APB_DW-1:0]   prdata_o,
    output logic                              pready_o,
    output logic                              pslverr_o,
    input  link_cfg_pkg::link_stat_t          stat_i,
    output link_cfg_pkg::link_cfg_t           cfg_o,
    output link_cfg_pkg::link_pulse_t         pulse_o
);
    import link_cfg_pkg::*;
    import link_sig_pkg::*;

    logic        access;
    logic        mapped;
    logic        read_only;
    logic        wr_en;
    link_cfg_t   cfg_q;
    link_pulse_t pulse_q;

    //////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////

    assign access = psel_i & penable_i;

    always_comb begin
        mapped    = 1'b1;
        read_only = 1'b0;
        case (paddr_i)
            ADDR_CTRL, ADDR_SEED, ADDR_EQN, ADDR_OSC, ADDR_TAPS: read_only = 1'b0;
            ADDR_ERR_CNT, ADDR_BIT_CNT, ADDR_STATUS:            read_only = 1'b1;
            default:                                            mapped    = 1'b0;
        endcase
    end

    // No wait states
    assign pready_o  = 1'b1;
    assign pslverr_o = access & (~mapped | (pwrite_i & read_only));
    assign wr_en     = access & pwrite_i & mapped & ~read_only;

    //////////////////////////////////////////////////
    // Configuration and pulses
    //////////////////////////////////////////////////

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            cfg_q.enable   <= 1'b0;
            cfg_q.seed     <= SEED_RST;
            cfg_q.eqn      <= EQN_RST;
            cfg_q.t_lo     <= OSC_RST;
            cfg_q.t_hi     <= OSC_RST;
            cfg_q.tap_main <= TAP_MAIN_RST;
            cfg_q.tap_post <= TAP_POST_RST;
            pulse_q        <= '0;
        end else begin
            // Pulses drop after one cycle
            pulse_q <= '0;
            if (wr_en) begin
                case (paddr_i)
                    ADDR_CTRL: begin
                        cfg_q.enable    <= pwdata_i[CTRL_EN_BIT];
                        pulse_q.inj_err <= pwdata_i[CTRL_INJ_BIT];
                        pulse_q.clear   <= pwdata_i[CTRL_CLR_BIT];
                    end
                    ADDR_SEED: cfg_q.seed <= pwdata_i[PRBS_W-1:0];
                    ADDR_EQN:  cfg_q.eqn  <= pwdata_i[PRBS_W-1:0];
                    ADDR_OSC: begin
                        cfg_q.t_lo <= pwdata_i[LO_FIELD_LSB +: OSC_W];
                        cfg_q.t_hi <= pwdata_i[HI_FIELD_LSB +: OSC_W];
                    end
                    ADDR_TAPS: begin
                        cfg_q.tap_main <= pwdata_i[LO_FIELD_LSB +: TAP_W];
                        cfg_q.tap_post <= pwdata_i[HI_FIELD_LSB +: TAP_W];
                    end
                    default: ;
                endcase
            end
        end
    end

    assign cfg_o   = cfg_q;
    assign pulse_o = pulse_q;

    //////////////////////////////////////////////////
    // Read mux
    //////////////////////////////////////////////////

    always_comb begin
        prdata_o = '0;
        case (paddr_i)
            ADDR_CTRL:    prdata_o[CTRL_EN_BIT] = cfg_q.enable;
            ADDR_SEED:    prdata_o[PRBS_W-1:0] = cfg_q.seed;
            ADDR_EQN:     prdata_o[PRBS_W-1:0] = cfg_q.eqn;
            ADDR_OSC: begin
                prdata_o[LO_FIELD_LSB +: OSC_W] = cfg_q.t_lo;
                prdata_o[HI_FIELD_LSB +: OSC_W] = cfg_q.t_hi;
            end
            ADDR_TAPS: begin
                prdata_o[LO_FIELD_LSB +: TAP_W] = cfg_q.tap_main;
                prdata_o[HI_FIELD_LSB +: TAP_W] = cfg_q.tap_post;
            end
            ADDR_ERR_CNT: prdata_o[ERR_CNT_W-1:0] = stat_i.err_cnt;
            ADDR_BIT_CNT: prdata_o[BIT_CNT_W-1:0] = stat_i.bit_cnt;
            ADDR_STATUS:  prdata_o[0] = stat_i.locked;
            default: ;
        endcase
    end

    // Access phase always comes right after its setup phase
    apb_setup_before_access: assert property (
        @(posedge emu_clk) disable iff (emu_rst)
        penable_i |-> psel_i && $past(psel_i && !penable_i)
    );

endmodule

// ==== rtl/tx_clk_osc.sv ====
`timescale 1ns/10ps

module tx_clk_osc (
    input  logic                    emu_clk,
    input  logic                    emu_rst,
    input  link_cfg_pkg::link_cfg_t cfg_i,
    output logic                    ui_stb_o
);
    import link_cfg_pkg::*;

    logic [OSC_W-1:0] cnt_q;
    logic             clk_val_q;
    logic             lo_done;
    logic             hi_done;

    assign lo_done = ~clk_val_q & (cnt_q == cfg_i.t_lo - 8'd1);
    assign hi_done =  clk_val_q & (cnt_q == cfg_i.t_hi - 8'd1);

    // Low phase first, then high phase
    always_ff @(posedge emu_clk) begin
        if (emu_rst || !cfg_i.enable) begin
            cnt_q     <= '0;
            clk_val_q <= 1'b0;
        end else if (lo_done || hi_done) begin
            cnt_q     <= '0;
            clk_val_q <= ~clk_val_q;
        end else begin
            cnt_q <= cnt_q + 8'd1;
        end
    end

    // Strobe on the low to high change
    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            ui_stb_o <= 1'b0;
        end else begin
            ui_stb_o <= cfg_i.enable & lo_done;
        end
    end

    osc_times_nonzero: assert property (
        @(posedge emu_clk) disable iff (emu_rst)
        cfg_i.enable |-> (cfg_i.t_lo != '0) && (cfg_i.t_hi != '0)
    );

endmodule

// ==== rtl/prbs_gen.sv ====
`timescale 1ns/10ps

module prbs_gen (
    input  logic                      emu_clk,
    input  logic                      emu_rst,
    input  link_cfg_pkg::link_cfg_t   cfg_i,
    input  logic                      inj_err_i,
    input  logic                      ui_stb_i,
    output link_sig_pkg::link_sym_t   sym_o
);
    import link_sig_pkg::*;

    logic [PRBS_W-1:0] state_q;
    logic              fb_bit;
    logic              inj_pend_q;
    logic              sym_vld_q;
    logic              sym_data_q;

    // Fibonacci feedback
    assign fb_bit = ^(state_q & cfg_i.eqn);

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            state_q    <= PRBS_W'(1);
            inj_pend_q <= 1'b0;
            sym_vld_q  <= 1'b0;
        end else begin
            sym_vld_q <= ui_stb_i;
            if (ui_stb_i) begin
                // A strobe in flight still shifts after disable
                state_q    <= {state_q[PRBS_W-2:0], fb_bit};
                inj_pend_q <= inj_err_i;
            end else begin
                inj_pend_q <= inj_pend_q | inj_err_i;
                if (!cfg_i.enable) begin
                    state_q <= cfg_i.seed;
                end
            end
        end
    end

    // Only the sent copy is flipped
    always_ff @(posedge emu_clk) begin
        if (ui_stb_i) begin
            sym_data_q <= fb_bit ^ inj_pend_q;
        end
    end

    assign sym_o.vld  = sym_vld_q;
    assign sym_o.data = sym_data_q;

    // All-zero state would lock up the sequence
    prbs_state_nonzero: assert property (
        @(posedge emu_clk) disable iff (emu_rst)
        cfg_i.enable |-> state_q != '0
    );

endmodule

// ==== rtl/chan_isi.sv ====
`timescale 1ns/10ps

module chan_isi (
    input  logic                      emu_clk,
    input  logic                      emu_rst,
    input  link_cfg_pkg::link_cfg_t   cfg_i,
    input  link_sig_pkg::link_sym_t   sym_i,
    output link_sig_pkg::link_smp_t   smp_o
);
    import link_sig_pkg::*;

    logic                    prev_q;
    logic                    smp_vld_q;
    logic signed [SMP_W-1:0] smp_q;
    logic signed [SMP_W-1:0] smp_d;

    // Tap times a +1 or -1 symbol
    function automatic logic signed [SMP_W-1:0] tap_term(
        input logic signed [TAP_W-1:0] tap,
        input logic                    data
    );
        logic signed [SMP_W-1:0] ext;
        ext = {{(SMP_W-TAP_W){tap[TAP_W-1]}}, tap};
        return data ? ext : -ext;
    endfunction

    //////////////////////////////////////////////////
    // Main cursor plus one postcursor
    //////////////////////////////////////////////////

    assign smp_d = tap_term(cfg_i.tap_main, sym_i.data) + tap_term(cfg_i.tap_post, prev_q);

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            prev_q    <= 1'b1;
            smp_vld_q <= 1'b0;
        end else begin
            smp_vld_q <= sym_i.vld;
            if (sym_i.vld) begin
                prev_q <= sym_i.data;
            end else if (!cfg_i.enable) begin
                // Idle line, next window starts from +1
                prev_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge emu_clk) begin
        if (sym_i.vld) begin
            smp_q <= smp_d;
        end
    end

    assign smp_o.vld = smp_vld_q;
    assign smp_o.smp = smp_q;

endmodule

// ==== rtl/rx_prbs_checker.sv ====
`timescale 1ns/10ps

module rx_prbs_checker (
    input  logic                      emu_clk,
    input  logic                      emu_rst,
    input  link_cfg_pkg::link_cfg_t   cfg_i,
    input  logic                      clear_i,
    input  link_sig_pkg::link_smp_t   smp_i,
    output link_cfg_pkg::link_stat_t  stat_o
);
    import link_sig_pkg::*;
    import link_cfg_pkg::*;

    logic                 rx_bit;
    logic                 pred_bit;
    logic                 chk_en;
    logic                 en_q;
    logic                 en_rise;
    logic [PRBS_W-1:0]    hist_q;
    logic [4:0]           rcv_cnt_q;
    logic                 locked_q;
    logic [ERR_CNT_W-1:0] err_cnt_q;
    logic [BIT_CNT_W-1:0] bit_cnt_q;

    //////////////////////////////////////////////////
    // Slicer and prediction
    //////////////////////////////////////////////////

    // Zero or positive slices to 1
    assign rx_bit   = ~smp_i.smp[SMP_W-1];
    assign pred_bit = ^(hist_q & cfg_i.eqn);
    assign chk_en   = smp_i.vld & cfg_i.enable;
    assign en_rise  = cfg_i.enable & ~en_q;

    // Sliced bit history, newest in bit 0
    always_ff @(posedge emu_clk) begin
        if (smp_i.vld) begin
            hist_q <= {hist_q[PRBS_W-2:0], rx_bit};
        end
    end

    // Lock after a full history of received bits
    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            en_q      <= 1'b0;
            rcv_cnt_q <= '0;
            locked_q  <= 1'b0;
        end else begin
            en_q <= cfg_i.enable;
            if (en_rise) begin
                rcv_cnt_q <= '0;
                locked_q  <= 1'b0;
            end else if (chk_en && !locked_q) begin
                rcv_cnt_q <= rcv_cnt_q + 5'd1;
                if (rcv_cnt_q == '1) begin
                    locked_q <= 1'b1;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Counters
    //////////////////////////////////////////////////

    always_ff @(posedge emu_clk) begin
        if (emu_rst || en_rise || clear_i) begin
            err_cnt_q <= '0;
            bit_cnt_q <= '0;
        end else if (chk_en && locked_q) begin
            bit_cnt_q <= bit_cnt_q + 32'd1;
            // Saturates at all ones
            if (rx_bit != pred_bit && err_cnt_q != '1) begin
                err_cnt_q <= err_cnt_q + 16'd1;
            end
        end
    end

    assign stat_o.err_cnt = err_cnt_q;
    assign stat_o.bit_cnt = bit_cnt_q;
    assign stat_o.locked  = locked_q;

endmodule

// ==== rtl/emu_link_top.sv ====
`timescale 1ns/10ps

module emu_link_top (
    input  logic                            emu_clk,
    input  logic                            emu_rst,
    input  logic [link_cfg_pkg::APB_AW-1:0] paddr_i,
    input  logic                            psel_i,
    input  logic                            penable_i,
    input  logic                            pwrite_i,
    input  logic [link_cfg_pkg::APB_DW-1:0] pwdata_i,
    output logic [link_cfg_pkg::APB_DW-1:0] prdata_o,
    output logic                            pready_o,
    output logic                            pslverr_o,
    output link_sig_pkg::link_smp_t         smp_o
);
    import link_cfg_pkg::*;
    import link_sig_pkg::*;

    link_cfg_t   cfg;
    link_pulse_t pulse;
    link_stat_t  stat;
    logic        ui_stb;
    link_sym_t   sym;
    link_smp_t   smp;

    //////////////////////////////////////////////////
    // Control
    //////////////////////////////////////////////////

    link_regs regs_i (
        .emu_clk   (emu_clk),
        .emu_rst   (emu_rst),
        .paddr_i   (paddr_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .stat_i    (stat),
        .cfg_o     (cfg),
        .pulse_o   (pulse)
    );

    tx_clk_osc osc_i (
        .emu_clk  (emu_clk),
        .emu_rst  (emu_rst),
        .cfg_i    (cfg),
        .ui_stb_o (ui_stb)
    );

    //////////////////////////////////////////////////
    // Datapath, strobe to counters in 3 cycles
    //////////////////////////////////////////////////

    prbs_gen prbs_i (
        .emu_clk   (emu_clk),
        .emu_rst   (emu_rst),
        .cfg_i     (cfg),
        .inj_err_i (pulse.inj_err),
        .ui_stb_i  (ui_stb),
        .sym_o     (sym)
    );

    chan_isi chan_i (
        .emu_clk (emu_clk),
        .emu_rst (emu_rst),
        .cfg_i   (cfg),
        .sym_i   (sym),
        .smp_o   (smp)
    );

    rx_prbs_checker chk_i (
        .emu_clk (emu_clk),
        .emu_rst (emu_rst),
        .cfg_i   (cfg),
        .clear_i (pulse.clear),
        .smp_i   (smp),
        .stat_o  (stat)
    );

    assign smp_o = smp;

endmodule

// ==== verification/link_monitor.sv ====
`timescale 1ns/10ps

module link_monitor (
    input  logic                            emu_clk,
    input  logic                            emu_rst,
    input  logic [link_cfg_pkg::APB_AW-1:0] paddr_i,
    input  logic                            psel_i,
    input  logic                            penable_i,
    input  logic                            pwrite_i,
    input  logic [link_cfg_pkg::APB_DW-1:0] pwdata_i,
    input  logic [link_cfg_pkg::APB_DW-1:0] prdata_i,
    input  logic                            pslverr_i,
    input  link_sig_pkg::link_smp_t         smp_i
);
    import link_cfg_pkg::*;
    import link_sig_pkg::*;

    string             test_name = "none";
    int                err_cnt = 0;
    int                chk_cnt = 0;

    link_cfg_t         sh;
    logic [PRBS_W-1:0] ref_state;
    logic              ref_prev;
    logic              inj_seen;
    int                win_cycles;
    int                last_bits;

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    // Symbol +1 or -1 weighted by each tap
    function automatic int chan_value(input logic signed [TAP_W-1:0] main,
                                      input logic signed [TAP_W-1:0] post,
                                      input logic cur, input logic prev);
        int m;
        int p;
        m = main;
        p = post;
        return (cur ? m : -m) + (prev ? p : -p);
    endfunction

    // Errors over the first nbits compared bits of a window
    function automatic int ref_err_count(input link_cfg_t c, input int nbits);
        logic [PRBS_W-1:0] tx_st;
        logic [PRBS_W-1:0] rx_hist;
        logic              prev;
        logic              tx;
        logic              rx;
        int                errs;
        tx_st   = c.seed;
        rx_hist = '0;
        prev    = 1'b1;
        errs    = 0;
        for (int n = 0; n < nbits + PRBS_W; n++) begin
            tx    = ^(tx_st & c.eqn);
            tx_st = {tx_st[PRBS_W-2:0], tx};
            rx    = chan_value(c.tap_main, c.tap_post, tx, prev) >= 0;
            prev  = tx;
            // First 32 bits only fill the history
            if (n >= PRBS_W && rx != ^(rx_hist & c.eqn)) begin
                errs++;
            end
            rx_hist = {rx_hist[PRBS_W-2:0], rx};
        end
        return (errs > 65535) ? 65535 : errs;
    endfunction

    function automatic logic [APB_DW-1:0] exp_read(input logic [APB_AW-1:0] addr);
        case (addr)
            ADDR_CTRL: return {31'b0, sh.enable};
            ADDR_SEED: return sh.seed;
            ADDR_EQN:  return sh.eqn;
            ADDR_OSC:  return {16'b0, sh.t_hi, sh.t_lo};
            ADDR_TAPS: return {16'b0, sh.tap_post, sh.tap_main};
            default:   return '0;
        endcase
    endfunction

    task automatic compare(input string what, input int exp, input int act);
        chk_cnt++;
        if (exp != act) begin
            err_cnt++;
            $display("mismatch %s %s: expected %0d, actual %0d", test_name, what, exp, act);
        end
    endtask

    //////////////////////////////////////////////////
    // APB accesses
    //////////////////////////////////////////////////

    task automatic check_read();
        int exp;
        case (paddr_i)
            ADDR_BIT_CNT: begin
                last_bits = prdata_i;
                if (!sh.enable && win_cycles != 0) begin
                    exp = win_cycles / (sh.t_lo + sh.t_hi);
                    chk_cnt++;
                    if (last_bits + 32 > exp + 2 || last_bits + 32 < exp - 2) begin
                        err_cnt++;
                        $display("mismatch %s bit rate: expected %0d, actual %0d",
                                 test_name, exp, last_bits + 32);
                    end
                end
            end
            ADDR_ERR_CNT: begin
                if (!sh.enable) begin
                    // One flipped bit hits every eqn tap and the bit itself
                    exp = inj_seen ? $countones(sh.eqn) + 1 : ref_err_count(sh, last_bits);
                    compare("ERR_CNT", exp, prdata_i);
                end
            end
            ADDR_STATUS: begin
                if (!sh.enable) begin
                    // Lock needs a full history of bits plus the pipeline delay
                    exp = win_cycles / (sh.t_lo + sh.t_hi) > PRBS_W + 2;
                    compare("STATUS", exp, prdata_i);
                end
            end
            default: compare("readback", exp_read(paddr_i), prdata_i);
        endcase
    endtask

    task automatic apply_write();
        case (paddr_i)
            ADDR_CTRL: begin
                if (pwdata_i[CTRL_EN_BIT] && !sh.enable) begin
                    ref_state  = sh.seed;
                    ref_prev   = 1'b1;
                    win_cycles = 0;
                    inj_seen   = 1'b0;
                end
                if (pwdata_i[CTRL_INJ_BIT] && sh.enable) begin
                    inj_seen = 1'b1;
                end
                sh.enable = pwdata_i[CTRL_EN_BIT];
            end
            ADDR_SEED: sh.seed = pwdata_i;
            ADDR_EQN:  sh.eqn  = pwdata_i;
            ADDR_OSC: begin
                sh.t_lo = pwdata_i[7:0];
                sh.t_hi = pwdata_i[15:8];
            end
            ADDR_TAPS: begin
                sh.tap_main = pwdata_i[7:0];
                sh.tap_post = pwdata_i[15:8];
            end
            default: ;
        endcase
    endtask

    task automatic check_sample();
        logic tx;
        tx        = ^(ref_state & sh.eqn);
        ref_state = {ref_state[PRBS_W-2:0], tx};
        compare("smp_o", chan_value(sh.tap_main, sh.tap_post, tx, ref_prev), smp_i.smp);
        ref_prev  = tx;
    endtask

    always @(posedge emu_clk) begin
        if (emu_rst) begin
            sh         = '{enable: 1'b0, seed: SEED_RST, eqn: EQN_RST, t_lo: OSC_RST,
                           t_hi: OSC_RST, tap_main: TAP_MAIN_RST, tap_post: TAP_POST_RST};
            inj_seen   = 1'b0;
            win_cycles = 0;
            last_bits  = 0;
        end else begin
            if (sh.enable) begin
                win_cycles++;
            end
            if (smp_i.vld && !inj_seen) begin
                check_sample();
            end
            if (psel_i && penable_i) begin
                case (paddr_i)
                    ADDR_CTRL, ADDR_SEED, ADDR_EQN, ADDR_OSC, ADDR_TAPS: begin
                        compare("pslverr", 0, pslverr_i);
                        if (pwrite_i) apply_write();
                        else check_read();
                    end
                    ADDR_ERR_CNT, ADDR_BIT_CNT, ADDR_STATUS: begin
                        compare("pslverr", pwrite_i, pslverr_i);
                        if (!pwrite_i) check_read();
                    end
                    default: compare("pslverr", 1, pslverr_i);
                endcase
            end
        end
    end

endmodule

// ==== verification/tb_emu_link.sv ====
`timescale 1ns/10ps

module tb_emu_link;
    import link_cfg_pkg::*;
    import link_sig_pkg::*;

    localparam int APB_TIMEOUT   = 16;
    localparam int LOCK_POLLS    = 200;
    localparam int DRAIN_TIMEOUT = 200;
    localparam logic [31:0] EQN_LONG = 32'h8020_0003;

    logic                emu_clk;
    logic                emu_rst;
    logic [APB_AW-1:0]   paddr;
    logic                psel;
    logic                penable;
    logic                pwrite;
    logic [APB_DW-1:0]   pwdata;
    logic [APB_DW-1:0]   prdata;
    logic                pready;
    logic                pslverr;
    link_smp_t           smp;

    logic [31:0] lfsr_q;
    logic [31:0] rnd;
    logic [31:0] rd_data;
    logic [7:0]  main_tap;
    logic [7:0]  post_tap;
    int          tests_run;
    int          tests_failed;
    int          timeouts;
    int          err_mark;
    int          to_mark;

    emu_link_top uut (
        .emu_clk   (emu_clk),
        .emu_rst   (emu_rst),
        .paddr_i   (paddr),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr),
        .smp_o     (smp)
    );

    link_monitor mon (
        .emu_clk   (emu_clk),
        .emu_rst   (emu_rst),
        .paddr_i   (paddr),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .pwdata_i  (pwdata),
        .prdata_i  (prdata),
        .pslverr_i (pslverr),
        .smp_i     (smp)
    );

    initial begin
        emu_clk = 1'b0;
        forever #10 emu_clk = ~emu_clk;
    end

    //////////////////////////////////////////////////
    // Random bits
    //////////////////////////////////////////////////

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    //////////////////////////////////////////////////
    // APB and waits
    //////////////////////////////////////////////////

    task automatic apb_xfer(input logic wr, input logic [APB_AW-1:0] addr,
                            input logic [APB_DW-1:0] wdata, output logic [APB_DW-1:0] rdata);
        int n;
        n = 0;
        @(posedge emu_clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge emu_clk);
        penable <= 1'b1;
        do begin
            @(posedge emu_clk);
            n++;
        end while (!pready && n < APB_TIMEOUT);
        if (!pready) begin
            timeouts++;
            $display("timeout: no pready on address %0h", addr);
        end
        rdata = prdata;
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic reg_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data);
        logic [APB_DW-1:0] unused;
        apb_xfer(1'b1, addr, data, unused);
    endtask

    task automatic reg_read(input logic [APB_AW-1:0] addr);
        apb_xfer(1'b0, addr, '0, rd_data);
    endtask

    task automatic wait_locked();
        int n;
        n = 0;
        rd_data = '0;
        while (!rd_data[0] && n < LOCK_POLLS) begin
            reg_read(ADDR_STATUS);
            n++;
        end
        if (!rd_data[0]) begin
            timeouts++;
            $display("timeout: link never locked");
        end
    endtask

    // Stop the link and wait until smp_o stays quiet
    task automatic stop_and_drain();
        int n;
        int quiet;
        n = 0;
        quiet = 0;
        reg_write(ADDR_CTRL, 32'h0);
        while (quiet < 8 && n < DRAIN_TIMEOUT) begin
            @(posedge emu_clk);
            quiet = smp.vld ? 0 : quiet + 1;
            n++;
        end
        if (quiet < 8) begin
            timeouts++;
            $display("timeout: samples still arriving after disable");
        end
    endtask

    task automatic read_results();
        reg_read(ADDR_BIT_CNT);
        reg_read(ADDR_ERR_CNT);
        reg_read(ADDR_STATUS);
    endtask

    task automatic begin_test(input string name);
        mon.test_name = name;
        err_mark = mon.err_cnt;
        to_mark = timeouts;
        tests_run++;
    endtask

    task automatic end_test();
        // Let the monitor finish the last access
        @(posedge emu_clk);
        if (mon.err_cnt != err_mark || timeouts != to_mark) begin
            tests_failed++;
            $display("test %s: fail", mon.test_name);
        end else begin
            $display("test %s: ok", mon.test_name);
        end
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        emu_rst = 1'b1;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        lfsr_q = 32'd91873;
        tests_run = 0;
        tests_failed = 0;
        timeouts = 0;
        repeat (8) @(posedge emu_clk);
        emu_rst <= 1'b0;

        begin_test("regs");
        reg_read(ADDR_SEED);
        reg_read(ADDR_TAPS);
        rand_bits(32, rnd);
        reg_write(ADDR_SEED, rnd);
        rand_bits(32, rnd);
        reg_write(ADDR_EQN, rnd);
        reg_write(ADDR_OSC, 32'h0000_0503);
        rand_bits(16, rnd);
        reg_write(ADDR_TAPS, rnd);
        reg_read(ADDR_SEED);
        reg_read(ADDR_EQN);
        reg_read(ADDR_OSC);
        reg_read(ADDR_TAPS);
        reg_read(ADDR_CTRL);
        read_results();
        reg_read(8'h20);
        reg_read(8'h44);
        reg_write(ADDR_ERR_CNT, 32'h1);
        reg_write(ADDR_BIT_CNT, 32'h1);
        reg_write(ADDR_STATUS, 32'h1);
        end_test();

        begin_test("samples");
        rand_bits(32, rnd);
        reg_write(ADDR_SEED, rnd | 32'h1);
        reg_write(ADDR_EQN, EQN_LONG);
        reg_write(ADDR_OSC, 32'h0000_0202);
        rand_bits(16, rnd);
        reg_write(ADDR_TAPS, rnd);
        reg_write(ADDR_CTRL, 32'h1);
        repeat (400) @(posedge emu_clk);
        stop_and_drain();
        read_results();
        end_test();

        begin_test("lock");
        reg_write(ADDR_SEED, 32'h1);
        reg_write(ADDR_EQN, 32'h60);
        reg_write(ADDR_TAPS, 32'h0000_0028);
        reg_write(ADDR_CTRL, 32'h1);
        wait_locked();
        repeat (100) @(posedge emu_clk);
        stop_and_drain();
        read_results();
        end_test();

        begin_test("inject");
        reg_write(ADDR_CTRL, 32'h1);
        wait_locked();
        repeat (40) @(posedge emu_clk);
        reg_write(ADDR_CTRL, 32'h3);
        repeat (200) @(posedge emu_clk);
        stop_and_drain();
        read_results();
        end_test();

        begin_test("isi");
        rand_bits(32, rnd);
        reg_write(ADDR_SEED, rnd | 32'h1);
        reg_write(ADDR_EQN, EQN_LONG);
        rand_bits(4, rnd);
        main_tap = 8'd16 + rnd[7:0];
        rand_bits(4, rnd);
        // Post tap outweighs main with opposite sign
        post_tap = -(main_tap + 8'd8 + rnd[7:0]);
        reg_write(ADDR_TAPS, {16'b0, post_tap, main_tap});
        reg_write(ADDR_CTRL, 32'h1);
        repeat (600) @(posedge emu_clk);
        stop_and_drain();
        read_results();
        end_test();

        begin_test("rate");
        reg_write(ADDR_SEED, 32'h1);
        reg_write(ADDR_EQN, 32'h60);
        reg_write(ADDR_TAPS, 32'h0000_0028);
        reg_write(ADDR_OSC, 32'h0000_0503);
        reg_write(ADDR_CTRL, 32'h1);
        repeat (1000) @(posedge emu_clk);
        stop_and_drain();
        read_results();
        end_test();

        $display("tests %0d, failed %0d, checks %0d, errors %0d, timeouts %0d",
                 tests_run, tests_failed, mon.chk_cnt, mon.err_cnt, timeouts);
        if (tests_failed == 0 && mon.err_cnt == 0 && timeouts == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== emu_link_top.f ====
rtl/link_sig_pkg.sv
rtl/link_cfg_pkg.sv
rtl/link_regs.sv
rtl/tx_clk_osc.sv
rtl/prbs_gen.sv
rtl/chan_isi.sv
rtl/rx_prbs_checker.sv
rtl/emu_link_top.sv
verification/link_monitor.sv
verification/tb_emu_link.sv

// ==== Bender.yml ====
package:
  name: emu_link

sources:
  - rtl/link_sig_pkg.sv
  - rtl/link_cfg_pkg.sv
  - rtl/link_regs.sv
  - rtl/tx_clk_osc.sv
  - rtl/prbs_gen.sv
  - rtl/chan_isi.sv
  - rtl/rx_prbs_checker.sv
  - rtl/emu_link_top.sv
  - target: test
    files:
      - verification/link_monitor.sv
      - verification/tb_emu_link.sv
